// ==== Makefile ====
LOG = sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove build output and log"
	@echo "make help   list these targets"

test:
	verilator --binary --timing --assert -Wno-fatal \
		--top-module axis_input_pipe_tb -f filelist.f
	./obj_dir/Vaxis_input_pipe_tb 2>&1 | tee $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== filelist.f ====
+incdir+src
src/conv_pkg.sv
src/axis_beat_if.sv
src/axis_reg_slice.sv
src/im_stream_tagger.sv
src/weights_rotator.sv
src/input_joiner.sv
src/axis_input_pipe.sv
tests/axis_input_pipe_props.sv
tests/axis_input_pipe_tb.sv

// ==== src/axis_beat_if.sv ====
`timescale 1ns/1ps

// valid/ready stream, payload type chosen per instance
interface axis_beat_if #(
  parameter type T = logic
);

  logic valid;
  logic ready;
  logic last;
  T     data;

  // data and last hold with valid until the beat transfers
  modport source (
    output valid,
    output last,
    output data,
    input  ready
  );

  modport sink (
    input  valid,
    input  last,
    input  data,
    output ready
  );

endinterface

// ==== src/axis_input_pipe.sv ====
`timescale 1ns/1ps

module axis_input_pipe import conv_pkg::*; (
  input  logic         aclk,
  input  logic         reset,
  input  logic         s_pixels_1_valid,
  output logic         s_pixels_1_ready,
  input  logic         s_pixels_1_last,
  input  pixel_beat_t  s_pixels_1_data,
  input  logic         s_pixels_2_valid,
  output logic         s_pixels_2_ready,
  input  logic         s_pixels_2_last,
  input  pixel_beat_t  s_pixels_2_data,
  input  logic         s_weights_valid,
  output logic         s_weights_ready,
  input  logic         s_weights_last,
  input  weight_beat_t s_weights_data,
  output logic         m_valid,
  input  logic         m_ready,
  output logic         m_last,
  output pixel_beat_t  m_pixels_1,
  output pixel_beat_t  m_pixels_2,
  output weight_beat_t m_weights,
  output conv_user_t   m_user
);

  axis_beat_if #(.T(pixel_beat_t))   px1_in ();
  axis_beat_if #(.T(pixel_beat_t))   px1_sliced ();
  axis_beat_if #(.T(tagged_pixel_t)) px1_tagged ();
  axis_beat_if #(.T(pixel_beat_t))   px2_in ();
  axis_beat_if #(.T(pixel_beat_t))   px2_sliced ();
  axis_beat_if #(.T(weight_beat_t))  w_in ();
  axis_beat_if #(.T(weight_beat_t))  w_sliced ();
  axis_beat_if #(.T(weight_beat_t))  w_rotated ();

  logic image_done;

  assign px1_in.valid     = s_pixels_1_valid;
  assign px1_in.last      = s_pixels_1_last;
  assign px1_in.data      = s_pixels_1_data;
  assign s_pixels_1_ready = px1_in.ready;

  assign px2_in.valid     = s_pixels_2_valid;
  assign px2_in.last      = s_pixels_2_last;
  assign px2_in.data      = s_pixels_2_data;
  assign s_pixels_2_ready = px2_in.ready;

  assign w_in.valid      = s_weights_valid;
  assign w_in.last       = s_weights_last;
  assign w_in.data       = s_weights_data;
  assign s_weights_ready = w_in.ready;

  axis_reg_slice #(.T(pixel_beat_t)) px1_slice (.aclk, .reset, .s(px1_in), .m(px1_sliced));
  axis_reg_slice #(.T(pixel_beat_t)) px2_slice (.aclk, .reset, .s(px2_in), .m(px2_sliced));
  axis_reg_slice #(.T(weight_beat_t)) w_slice (.aclk, .reset, .s(w_in), .m(w_sliced));

  im_stream_tagger tagger (.aclk, .reset, .s(px1_sliced), .m(px1_tagged));

  weights_rotator rotator (.aclk, .reset, .image_done, .s(w_sliced), .m(w_rotated));

  input_joiner joiner (
    .pixels_1   (px1_tagged),
    .pixels_2   (px2_sliced),
    .weights    (w_rotated),
    .m_valid, .m_ready, .m_last,
    .m_pixels_1, .m_pixels_2, .m_weights, .m_user,
    .image_done
  );

endmodule

// ==== src/axis_reg_slice.sv ====
`timescale 1ns/1ps

module axis_reg_slice #(
  parameter type T = logic
) (
  input  logic        aclk,
  input  logic        reset,
  axis_beat_if.sink   s,
  axis_beat_if.source m
);

  T     main_data;
  T     skid_data;
  logic main_valid;
  logic main_last;
  logic skid_valid;
  logic skid_last;
  logic main_free;

  assign s.ready   = !skid_valid;  // only from local state
  assign main_free = !main_valid || m.ready;

  assign m.valid = main_valid;
  assign m.last  = main_last;
  assign m.data  = main_data;

  always_ff @(posedge aclk) begin
    if (reset) begin
      main_valid <= 1'b0;
      main_last  <= 1'b0;
      skid_valid <= 1'b0;
      skid_last  <= 1'b0;
    end else if (main_free) begin
      main_valid <= skid_valid || s.valid;  // spare drains first
      main_last  <= skid_valid ? skid_last : s.last;
      skid_valid <= 1'b0;
    end else if (s.valid && !skid_valid) begin
      skid_valid <= 1'b1;  // output stalled, park the beat
      skid_last  <= s.last;
    end
  end

  always_ff @(posedge aclk) begin
    if (main_free) main_data <= skid_valid ? skid_data : s.data;
    if (!skid_valid) skid_data <= s.data;  // only kept when skid_valid sets
  end

endmodule

// ==== src/conv_config.svh ====
`ifndef CONV_CONFIG_SVH
`define CONV_CONFIG_SVH

// word and array geometry
`define WORD_WIDTH     8
`define UNITS          2    // rows produced per block
`define KERNEL_H_MAX   3
`define KERNEL_W_MAX   3
`define CORES          2    // weight lanes

// image limits
`define IM_CIN_MAX     4
`define IM_COLS_MAX    8
`define IM_BLOCKS_MAX  4

// units plus kernel halo, rounded up to a power of two
`define IM_IN_WORDS    (2 ** $clog2(`UNITS + `KERNEL_H_MAX - 1))

`endif

// ==== src/conv_pkg.sv ====
`include "conv_config.svh"

package conv_pkg;

  typedef logic [`WORD_WIDTH-1:0] word_t;

  typedef word_t [`IM_IN_WORDS-1:0] pixel_beat_t;  // word 0 in the low bits
  typedef word_t [`CORES-1:0][`KERNEL_W_MAX-1:0] weight_beat_t;

  typedef logic [$clog2(`IM_BLOCKS_MAX+1)-1:0] blocks_t;
  typedef logic [$clog2(`IM_COLS_MAX+1)-1:0]   cols_t;
  typedef logic [$clog2(`IM_CIN_MAX+1)-1:0]    cin_t;

  // decoded from header words 0..3, flags live in word 3 bits 0..2
  typedef struct packed {
    blocks_t blocks;
    cols_t   cols;
    cin_t    cin;
    logic    is_max;
    logic    is_lrelu;
    logic    is_1x1;
  } im_config_t;

  typedef struct packed {
    logic is_top_block;
    logic is_bottom_block;
    logic is_cin_last;
    logic is_col_last;
    logic is_max;
    logic is_lrelu;
    logic is_1x1;
  } conv_user_t;

  typedef struct packed {
    conv_user_t  user;
    pixel_beat_t pixels;
  } tagged_pixel_t;

endpackage

// ==== src/im_stream_tagger.sv ====
`timescale 1ns/1ps

module im_stream_tagger import conv_pkg::*; (
  input  logic        aclk,
  input  logic        reset,
  axis_beat_if.sink   s,
  axis_beat_if.source m
);

  im_config_t cfg;
  logic       header_pending;  // next input beat is a header
  blocks_t    blk_cnt;
  cols_t      col_cnt;
  cin_t       cin_cnt;
  logic       cin_last;
  logic       col_last;
  logic       blk_last;
  logic       beat_last;
  logic       take;
  conv_user_t user;

  assign cin_last  = cin_cnt == cfg.cin - 1'b1;
  assign col_last  = col_cnt == cfg.cols - 1'b1;
  assign blk_last  = blk_cnt == cfg.blocks - 1'b1;
  assign beat_last = blk_last && col_last && cin_last;

  // header is always taken, image beats need room in the output register
  assign s.ready = header_pending || !m.valid || m.ready;
  assign take    = s.valid && s.ready && !header_pending;

  always_comb begin
    user.is_top_block    = blk_cnt == '0;
    user.is_bottom_block = blk_last;
    user.is_cin_last     = cin_last;
    user.is_col_last     = col_last;
    user.is_max          = cfg.is_max;
    user.is_lrelu        = cfg.is_lrelu;
    user.is_1x1          = cfg.is_1x1;
  end

  always_ff @(posedge aclk) begin
    if (reset) begin
      header_pending <= 1'b1;
      m.valid        <= 1'b0;
      m.last         <= 1'b0;
      blk_cnt        <= '0;
      col_cnt        <= '0;
      cin_cnt        <= '0;
    end else begin
      if (header_pending && s.valid) header_pending <= 1'b0;

      if (take) begin
        m.valid <= 1'b1;
        m.last  <= beat_last;
        // channel fastest, then column, then block
        cin_cnt <= cin_last ? '0 : cin_cnt + 1'b1;
        if (cin_last) col_cnt <= col_last ? '0 : col_cnt + 1'b1;
        if (cin_last && col_last) blk_cnt <= blk_last ? '0 : blk_cnt + 1'b1;
        if (beat_last) header_pending <= 1'b1;
      end else if (m.ready) begin
        m.valid <= 1'b0;
        m.last  <= 1'b0;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (header_pending && s.valid) begin
      cfg.blocks   <= blocks_t'(s.data[0]);
      cfg.cols     <= cols_t'(s.data[1]);
      cfg.cin      <= cin_t'(s.data[2]);
      cfg.is_max   <= s.data[3][0];
      cfg.is_lrelu <= s.data[3][1];
      cfg.is_1x1   <= s.data[3][2];
    end
    if (take) begin
      m.data.user   <= user;
      m.data.pixels <= s.data;
    end
  end

endmodule

// ==== src/input_joiner.sv ====
`timescale 1ns/1ps

module input_joiner import conv_pkg::*; (
  axis_beat_if.sink    pixels_1,
  axis_beat_if.sink    pixels_2,
  axis_beat_if.sink    weights,
  output logic         m_valid,
  input  logic         m_ready,
  output logic         m_last,
  output pixel_beat_t  m_pixels_1,
  output pixel_beat_t  m_pixels_2,
  output weight_beat_t m_weights,
  output conv_user_t   m_user,
  output logic         image_done
);

  // a beat moves only when all three sides have one
  assign m_valid = pixels_1.valid && pixels_2.valid && weights.valid;

  assign pixels_1.ready = m_ready && pixels_2.valid && weights.valid;
  assign pixels_2.ready = m_ready && pixels_1.valid && weights.valid;
  assign weights.ready  = m_ready && pixels_1.valid && pixels_2.valid;

  assign m_last     = pixels_1.last;  // image framing follows pixel 1
  assign m_user     = pixels_1.data.user;
  assign m_pixels_1 = pixels_1.data.pixels;
  assign m_pixels_2 = pixels_2.data;
  assign m_weights  = weights.data;

  assign image_done = m_valid && m_ready && m_last;

endmodule

// ==== src/weights_rotator.sv ====
`timescale 1ns/1ps
`include "conv_config.svh"

module weights_rotator import conv_pkg::*; (
  input  logic        aclk,
  input  logic        reset,
  input  logic        image_done,
  axis_beat_if.sink   s,
  axis_beat_if.source m
);

  localparam int IDX_W = $clog2(`IM_CIN_MAX);

  weight_beat_t     mem [`IM_CIN_MAX];  // one entry per input channel
  logic             loading;
  cin_t             count;
  logic [IDX_W-1:0] wr_idx;
  logic [IDX_W-1:0] rd_idx;
  logic             rd_wrap;
  logic             load_beat;

  assign wr_idx    = count[IDX_W-1:0];
  assign rd_wrap   = cin_t'(rd_idx) == count - 1'b1;
  assign load_beat = s.valid && s.ready;

  assign s.ready = loading;
  assign m.valid = !loading;
  assign m.data  = mem[rd_idx];
  assign m.last  = rd_wrap;  // final channel of one rotation

  always_ff @(posedge aclk) begin
    if (reset) begin
      loading <= 1'b1;
      count   <= '0;
      rd_idx  <= '0;
    end else if (image_done) begin
      loading <= 1'b1;  // next image brings its own weights
      count   <= '0;
      rd_idx  <= '0;
    end else if (loading) begin
      if (load_beat) begin
        count <= count + 1'b1;
        if (s.last) loading <= 1'b0;
      end
    end else if (m.valid && m.ready) begin
      rd_idx <= rd_wrap ? '0 : rd_idx + 1'b1;
    end
  end

  // channel counts above IM_CIN_MAX would wrap the write index
  always_ff @(posedge aclk) begin
    if (load_beat) mem[wr_idx] <= s.data;
  end

endmodule

// ==== tests/axis_input_pipe_props.sv ====
`timescale 1ns/1ps

module axis_input_pipe_props import conv_pkg::*; (
  input logic         aclk,
  input logic         reset,
  input logic         m_valid,
  input logic         m_ready,
  input logic         m_last,
  input pixel_beat_t  m_pixels_1,
  input pixel_beat_t  m_pixels_2,
  input weight_beat_t m_weights,
  input conv_user_t   m_user,
  input logic         image_done
);

  // a stalled beat keeps its contents
  assert property (@(posedge aclk) disable iff (reset)
    m_valid && !m_ready |=> m_valid && $stable(m_pixels_1) && $stable(m_pixels_2)
      && $stable(m_weights) && $stable(m_user) && $stable(m_last))
    else $error("output beat changed while stalled");

  assert property (@(posedge aclk) reset && $past(reset) |-> !m_valid && !image_done)
    else $error("valid high during reset");

  // next image waits for its own weights
  assert property (@(posedge aclk) disable iff (reset)
    image_done |=> !m_valid)
    else $error("output beat right after image_done without reloaded weights");

endmodule

bind axis_input_pipe axis_input_pipe_props props_inst (.*);

// ==== tests/axis_input_pipe_tb.sv ====
`timescale 1ns/1ps
`include "conv_config.svh"

module axis_input_pipe_tb import conv_pkg::*; ();

  logic         aclk;
  logic         reset;
  logic         s_pixels_1_valid;
  logic         s_pixels_1_ready;
  logic         s_pixels_1_last;
  pixel_beat_t  s_pixels_1_data;
  logic         s_pixels_2_valid;
  logic         s_pixels_2_ready;
  logic         s_pixels_2_last;
  pixel_beat_t  s_pixels_2_data;
  logic         s_weights_valid;
  logic         s_weights_ready;
  logic         s_weights_last;
  weight_beat_t s_weights_data;
  logic         m_valid;
  logic         m_ready;
  logic         m_last;
  pixel_beat_t  m_pixels_1;
  pixel_beat_t  m_pixels_2;
  weight_beat_t m_weights;
  conv_user_t   m_user;

  // input streams with the header beat at the front of pixel 1
  pixel_beat_t  p1_q[$];
  logic         p1_last_q[$];
  pixel_beat_t  p2_q[$];
  logic         p2_last_q[$];
  weight_beat_t w_q[$];
  logic         w_last_q[$];

  // expected output beats
  pixel_beat_t  exp_p1[$];
  pixel_beat_t  exp_p2[$];
  weight_beat_t exp_w[$];
  conv_user_t   exp_user[$];
  logic         exp_last[$];

  int          total_beats = 0;
  logic        patterns_loaded = 1'b0;
  logic        drive_done = 1'b0;
  logic [31:0] lfsr = 32'd71432;

  axis_input_pipe axis_input_pipe_inst (.*);

  function automatic logic rand_bit();
    logic b;
    b = lfsr[0];
    lfsr = lfsr >> 1;
    if (b) lfsr = lfsr ^ 32'h8020_0003;  // galois taps in shift right form
    return b;
  endfunction

  function automatic logic take_gap();
    logic a;
    logic b;
    a = rand_bit();
    b = rand_bit();
    return a && b;  // roughly one cycle in four
  endfunction

  task automatic fail_now(string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic compare_pixels(string name, pixel_beat_t exp, pixel_beat_t act);
    if (exp !== act) fail_now($sformatf("ERROR %s expected %h actual %h", name, exp, act));
  endtask

  task automatic compare_weights(string name, weight_beat_t exp, weight_beat_t act);
    if (exp !== act) fail_now($sformatf("ERROR %s expected %h actual %h", name, exp, act));
  endtask

  task automatic compare_user(string name, conv_user_t exp, conv_user_t act);
    if (exp !== act) fail_now($sformatf("ERROR %s expected %b actual %b", name, exp, act));
  endtask

  task automatic compare_last(string name, logic exp, logic act);
    if (exp !== act) fail_now($sformatf("ERROR %s expected %b actual %b", name, exp, act));
  endtask

  // reads H, W and P lines and builds one expected beat per P line
  task automatic load_patterns();
    int           fd;
    int           n;
    int           v[8];
    int           blocks, cols, cin, flags;
    int           j, wi, ch, col, blk;
    string        line;
    pixel_beat_t  px;
    weight_beat_t wb;
    weight_beat_t run_w[$];
    conv_user_t   u;
    fd = $fopen("tests/input_pipe_patterns.txt", "r");
    if (fd == 0) fail_now("cannot open the pattern file");
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n < 2 || line.getc(0) == "#") continue;
      if (line.getc(0) == "H") begin
        n = $sscanf(line, "H %d %d %d %d", blocks, cols, cin, flags);
        if (n != 4) fail_now("a header line in the pattern file has too few fields");
        px = '0;
        px[0] = word_t'(blocks);
        px[1] = word_t'(cols);
        px[2] = word_t'(cin);
        px[3] = word_t'(flags);
        p1_q.push_back(px);
        p1_last_q.push_back(1'b0);
        run_w.delete();
        j = 0;
        wi = 0;
      end else if (line.getc(0) == "W") begin
        n = $sscanf(line, "W %d %d %d %d %d %d", v[0], v[1], v[2], v[3], v[4], v[5]);
        if (n != 6) fail_now("a weight line in the pattern file has too few fields");
        for (int c = 0; c < `CORES; c++)
          for (int k = 0; k < `KERNEL_W_MAX; k++) wb[c][k] = word_t'(v[c*`KERNEL_W_MAX+k]);
        run_w.push_back(wb);
        w_q.push_back(wb);
        w_last_q.push_back(wi == cin - 1);
        wi++;
      end else if (line.getc(0) == "P") begin
        n = $sscanf(line, "P %d %d %d %d %d %d %d %d",
                    v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]);
        if (n != 8) fail_now("a pixel line in the pattern file has too few fields");
        for (int k = 0; k < 4; k++) px[k] = word_t'(v[k]);
        p1_q.push_back(px);
        p1_last_q.push_back(j == blocks*cols*cin - 1);
        exp_p1.push_back(px);
        for (int k = 0; k < 4; k++) px[k] = word_t'(v[4+k]);
        p2_q.push_back(px);
        p2_last_q.push_back(j == blocks*cols*cin - 1);
        exp_p2.push_back(px);
        ch  = j % cin;  // channel runs fastest
        col = (j / cin) % cols;
        blk = j / (cin*cols);
        exp_w.push_back(run_w[ch]);
        u.is_top_block    = blk == 0;
        u.is_bottom_block = blk == blocks - 1;
        u.is_cin_last     = ch == cin - 1;
        u.is_col_last     = col == cols - 1;
        u.is_max          = flags[0];
        u.is_lrelu        = flags[1];
        u.is_1x1          = flags[2];
        exp_user.push_back(u);
        exp_last.push_back(j == blocks*cols*cin - 1);
        j++;
        total_beats++;
      end
    end
    $fclose(fd);
  endtask

  initial begin
    aclk = 1'b0;
    forever #2 aclk = ~aclk;
  end

  initial begin
    string name;
    int    seen;
    reset = 1'b1;
    {s_pixels_1_valid, s_pixels_1_last, s_pixels_1_data} = '0;
    {s_pixels_2_valid, s_pixels_2_last, s_pixels_2_data} = '0;
    {s_weights_valid, s_weights_last, s_weights_data} = '0;
    m_ready = 1'b0;
    seen = 0;
    load_patterns();
    patterns_loaded = 1'b1;
    repeat (8) @(posedge aclk);
    @(negedge aclk);
    reset = 1'b0;
    fork
      while (p1_q.size() > 0) begin
        while (take_gap()) @(negedge aclk);
        s_pixels_1_valid = 1'b1;
        s_pixels_1_data  = p1_q.pop_front();
        s_pixels_1_last  = p1_last_q.pop_front();
        @(posedge aclk);
        while (!s_pixels_1_ready) @(posedge aclk);
        @(negedge aclk);
        s_pixels_1_valid = 1'b0;
      end
      while (p2_q.size() > 0) begin
        while (take_gap()) @(negedge aclk);
        s_pixels_2_valid = 1'b1;
        s_pixels_2_data  = p2_q.pop_front();
        s_pixels_2_last  = p2_last_q.pop_front();
        @(posedge aclk);
        while (!s_pixels_2_ready) @(posedge aclk);
        @(negedge aclk);
        s_pixels_2_valid = 1'b0;
      end
      while (w_q.size() > 0) begin
        while (take_gap()) @(negedge aclk);
        s_weights_valid = 1'b1;
        s_weights_data  = w_q.pop_front();
        s_weights_last  = w_last_q.pop_front();
        @(posedge aclk);
        while (!s_weights_ready) @(posedge aclk);
        @(negedge aclk);
        s_weights_valid = 1'b0;
      end
      while (!drive_done) begin
        @(negedge aclk);
        m_ready = !take_gap();
      end
      begin
        while (seen < total_beats) begin
          @(posedge aclk);
          if (m_valid && m_ready) begin
            name = $sformatf("beat %0d", seen);
            compare_pixels({name, " pixels_1"}, exp_p1.pop_front(), m_pixels_1);
            compare_pixels({name, " pixels_2"}, exp_p2.pop_front(), m_pixels_2);
            compare_weights({name, " weights"}, exp_w.pop_front(), m_weights);
            compare_user({name, " user"}, exp_user.pop_front(), m_user);
            compare_last({name, " last"}, exp_last.pop_front(), m_last);
            seen++;
          end
        end
        drive_done = 1'b1;
      end
    join
    repeat (4) begin
      @(posedge aclk);
      if (m_valid) fail_now("an extra output beat appeared after the last image");
    end
    $display("All tests passed");
    $finish;
  end

  // 40 cycles allowed per expected beat
  initial begin
    wait (patterns_loaded);
    repeat (8 + 40 * total_beats) @(posedge aclk);
    $display("timeout: output beats stopped arriving");
    $display("Some tests failed");
    $fatal(1, "watchdog expired");
  end

endmodule

// ==== tests/input_pipe_patterns.txt ====
# H blocks cols channels flags (bit0 max, bit1 lrelu, bit2 1x1)
# W six weight words, core 0 then core 1
# P four pixel-1 words then four pixel-2 words
H 2 2 2 0
W 11 12 13 14 15 16
W 21 22 23 24 25 26
P 1 2 3 4 101 102 103 104
P 5 6 7 8 105 106 107 108
P 9 10 11 12 109 110 111 112
P 13 14 15 16 113 114 115 116
P 17 18 19 20 117 118 119 120
P 21 22 23 24 121 122 123 124
P 25 26 27 28 125 126 127 128
P 29 30 31 32 129 130 131 132
H 1 3 2 7
W 31 32 33 34 35 36
W 41 42 43 44 45 46
P 33 34 35 36 133 134 135 136
P 37 38 39 40 137 138 139 140
P 41 42 43 44 141 142 143 144
P 45 46 47 48 145 146 147 148
P 49 50 51 52 149 150 151 152
P 53 54 55 56 153 154 155 156
H 2 1 3 1
W 51 52 53 54 55 56
W 61 62 63 64 65 66
W 71 72 73 74 75 76
P 57 58 59 60 157 158 159 160
P 61 62 63 64 161 162 163 164
P 65 66 67 68 165 166 167 168
P 69 70 71 72 169 170 171 172
P 73 74 75 76 173 174 175 176
P 77 78 79 80 177 178 179 180
